/* source/fe_params_pkg.sv */
`default_nettype none

package fe_params_pkg;

    // address and instruction width
    localparam int XLEN = 32;
    localparam int ORDER_BITS = 64;

    // line geometry
    localparam int LINE_BITS = 256;
    localparam int BEAT_BITS = 64;
    localparam int BEATS_PER_LINE = 4;
    localparam int WORDS_PER_LINE = 8;
    localparam int OFFSET_BITS = 5;
    localparam int WORD_SEL_BITS = $clog2(WORDS_PER_LINE);
    localparam int BEAT_CNT_BITS = $clog2(BEATS_PER_LINE);

    // instruction queue
    localparam int QUEUE_DEPTH = 16;
    localparam int QUEUE_PTR_BITS = $clog2(QUEUE_DEPTH);

    localparam logic [XLEN-1:0] RESET_PC = 32'h6000_0000;

endpackage

`default_nettype wire

/* source/fe_types_pkg.sv */
`default_nettype none

package fe_types_pkg;

    // one fetched instruction, 128 bits
    typedef struct packed {
        logic [fe_params_pkg::ORDER_BITS-1:0] order;
        logic [fe_params_pkg::XLEN-1:0]       pc;
        logic [fe_params_pkg::XLEN-1:0]       inst;
    } fetch_entry_t;

    typedef enum logic {
        FETCH_RUN,
        FETCH_WAIT_LINE
    } fetch_state_e;

    typedef enum logic [1:0] {
        GRANT_NONE,
        GRANT_INST,
        GRANT_DATA
    } grant_e;

    typedef enum logic [1:0] {
        DESER_IDLE,
        DESER_ISSUE,
        DESER_COLLECT
    } deser_state_e;

endpackage

`default_nettype wire

/* source/line_req_if.sv */
`timescale 1ns/1ns
`default_nettype none

// one line read requester and its responder
interface line_req_if;

    logic                                req;
    logic [fe_params_pkg::XLEN-1:0]      addr;
    logic [fe_params_pkg::LINE_BITS-1:0] line;
    // single cycle, line valid alongside
    logic                                resp;

    modport requester (
        output req,
        output addr,
        input  line,
        input  resp
    );

    modport responder (
        input  req,
        input  addr,
        output line,
        output resp
    );

endinterface

`default_nettype wire

/* source/fetch_unit.sv */
`timescale 1ns/1ns
`default_nettype none

module fetch_unit (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              redirect_i,
    input  logic [fe_params_pkg::XLEN-1:0]    redirect_pc_i,
    input  logic                              q_full_i,
    input  logic                              q_pop_i,
    output logic                              q_push_o,
    output fe_types_pkg::fetch_entry_t        q_entry_o,
    output logic                              q_flush_o,
    line_req_if.requester                     inst_line
);

    fe_types_pkg::fetch_state_e state_q;

    logic [fe_params_pkg::XLEN-1:0]                          pc_q;
    logic [fe_params_pkg::ORDER_BITS-1:0]                    order_q;
    logic [fe_params_pkg::ORDER_BITS-1:0]                    pop_cnt_q;
    logic [fe_params_pkg::ORDER_BITS-1:0]                    pop_cnt_next;
    logic [fe_params_pkg::LINE_BITS-1:0]                     line_buf_q;
    logic [fe_params_pkg::XLEN-1:fe_params_pkg::OFFSET_BITS] line_tag_q;
    logic                                                    line_valid_q;
    logic [fe_params_pkg::XLEN-1:0]                          req_addr_q;
    logic                                                    req_q;
    logic                                                    hit;
    logic [fe_params_pkg::WORD_SEL_BITS-1:0]                 word_sel;

    assign word_sel = pc_q[fe_params_pkg::OFFSET_BITS-1:2];
    assign hit = line_valid_q &&
                 (line_tag_q == pc_q[fe_params_pkg::XLEN-1:fe_params_pkg::OFFSET_BITS]);

    // handshakes done at the queue head, including this cycle
    assign pop_cnt_next = pop_cnt_q + {{(fe_params_pkg::ORDER_BITS-1){1'b0}}, q_pop_i};

    assign q_flush_o = redirect_i;
    assign q_push_o  = (state_q == fe_types_pkg::FETCH_RUN) && hit && !q_full_i && !redirect_i;
    assign q_entry_o = '{
        order: order_q,
        pc:    pc_q,
        inst:  line_buf_q[word_sel*fe_params_pkg::XLEN +: fe_params_pkg::XLEN]
    };

    assign inst_line.req  = req_q;
    assign inst_line.addr = req_addr_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q      <= fe_types_pkg::FETCH_RUN;
            pc_q         <= fe_params_pkg::RESET_PC;
            order_q      <= '0;
            pop_cnt_q    <= '0;
            line_valid_q <= 1'b0;
            req_q        <= 1'b0;
        end else begin
            pop_cnt_q <= pop_cnt_next;

            if (redirect_i) begin
                pc_q    <= redirect_pc_i;
                order_q <= pop_cnt_next;
            end else if (q_push_o) begin
                pc_q    <= pc_q + 32'd4;
                order_q <= order_q + 64'd1;
            end

            case (state_q)
                fe_types_pkg::FETCH_RUN: begin
                    if (!hit && !redirect_i) begin
                        req_q   <= 1'b1;
                        state_q <= fe_types_pkg::FETCH_WAIT_LINE;
                    end
                end
                fe_types_pkg::FETCH_WAIT_LINE: begin
                    // a redirect here still waits for the fill
                    if (inst_line.resp) begin
                        req_q        <= 1'b0;
                        line_valid_q <= 1'b1;
                        state_q      <= fe_types_pkg::FETCH_RUN;
                    end
                end
                default: state_q <= fe_types_pkg::FETCH_RUN;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == fe_types_pkg::FETCH_RUN && !hit) begin
            req_addr_q <= {pc_q[fe_params_pkg::XLEN-1:fe_params_pkg::OFFSET_BITS],
                           {fe_params_pkg::OFFSET_BITS{1'b0}}};
        end
        if (state_q == fe_types_pkg::FETCH_WAIT_LINE && inst_line.resp) begin
            line_buf_q <= inst_line.line;
            line_tag_q <= req_addr_q[fe_params_pkg::XLEN-1:fe_params_pkg::OFFSET_BITS];
        end
    end

endmodule

`default_nettype wire

/* source/inst_queue.sv */
`timescale 1ns/1ns
`default_nettype none

module inst_queue (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       flush_i,
    input  logic                       push_i,
    input  fe_types_pkg::fetch_entry_t entry_i,
    output logic                       full_o,
    output logic                       pop_o,
    output logic                       head_valid_o,
    output fe_types_pkg::fetch_entry_t head_o,
    input  logic                       head_ready_i
);

    fe_types_pkg::fetch_entry_t mem [fe_params_pkg::QUEUE_DEPTH];

    logic [fe_params_pkg::QUEUE_PTR_BITS-1:0] head_q;
    logic [fe_params_pkg::QUEUE_PTR_BITS-1:0] tail_q;
    logic [fe_params_pkg::QUEUE_PTR_BITS:0]   count_q;

    assign full_o       = (count_q == fe_params_pkg::QUEUE_DEPTH);
    assign head_valid_o = (count_q != '0);
    assign head_o       = mem[head_q];
    assign pop_o        = head_valid_o && head_ready_i;

    always_ff @(posedge clk) begin
        if (rst || flush_i) begin
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
        end else begin
            if (push_i) begin
                tail_q <= tail_q + 1'b1;
            end
            if (pop_o) begin
                head_q <= head_q + 1'b1;
            end
            // pointers wrap on their own, depth is a power of two
            if (push_i && !pop_o) begin
                count_q <= count_q + 1'b1;
            end else if (pop_o && !push_i) begin
                count_q <= count_q - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (push_i) begin
            mem[tail_q] <= entry_i;
        end
    end

endmodule

`default_nettype wire

/* source/line_arbiter.sv */
`timescale 1ns/1ns
`default_nettype none

module line_arbiter (
    input  logic          clk,
    input  logic          rst,
    line_req_if.responder inst_line,
    line_req_if.responder data_line,
    line_req_if.requester mem_line
);

    fe_types_pkg::grant_e grant_q;
    fe_types_pkg::grant_e sel;

    // new grant only while idle, data first
    always_comb begin
        sel = grant_q;
        if (grant_q == fe_types_pkg::GRANT_NONE) begin
            if (data_line.req) begin
                sel = fe_types_pkg::GRANT_DATA;
            end else if (inst_line.req) begin
                sel = fe_types_pkg::GRANT_INST;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            grant_q <= fe_types_pkg::GRANT_NONE;
        end else if (mem_line.resp) begin
            grant_q <= fe_types_pkg::GRANT_NONE;
        end else begin
            grant_q <= sel;
        end
    end

    assign mem_line.req  = (sel != fe_types_pkg::GRANT_NONE);
    assign mem_line.addr = (sel == fe_types_pkg::GRANT_DATA) ? data_line.addr : inst_line.addr;

    // route the line back to the granted side only
    assign data_line.resp = mem_line.resp && (sel == fe_types_pkg::GRANT_DATA);
    assign inst_line.resp = mem_line.resp && (sel == fe_types_pkg::GRANT_INST);
    assign data_line.line = (sel == fe_types_pkg::GRANT_DATA) ? mem_line.line : '0;
    assign inst_line.line = (sel == fe_types_pkg::GRANT_INST) ? mem_line.line : '0;

endmodule

`default_nettype wire

/* source/burst_deserializer.sv */
`timescale 1ns/1ns
`default_nettype none

module burst_deserializer (
    input  logic                                clk,
    input  logic                                rst,
    line_req_if.responder                       mem_line,
    output logic [fe_params_pkg::XLEN-1:0]      bmem_addr_o,
    output logic                                bmem_read_o,
    input  logic                                bmem_ready_i,
    input  logic [fe_params_pkg::XLEN-1:0]      bmem_raddr_i,
    input  logic [fe_params_pkg::BEAT_BITS-1:0] bmem_rdata_i,
    input  logic                                bmem_rvalid_i
);

    fe_types_pkg::deser_state_e state_q;

    logic [fe_params_pkg::XLEN-1:0]          addr_q;
    logic [fe_params_pkg::LINE_BITS-1:0]     line_q;
    logic [fe_params_pkg::BEAT_CNT_BITS-1:0] beat_cnt_q;
    logic                                    resp_q;
    logic                                    beat_hit;

    assign beat_hit    = bmem_rvalid_i && (bmem_raddr_i == addr_q);
    assign bmem_addr_o = addr_q;
    assign bmem_read_o = (state_q == fe_types_pkg::DESER_ISSUE) && bmem_ready_i;

    assign mem_line.line = line_q;
    assign mem_line.resp = resp_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q    <= fe_types_pkg::DESER_IDLE;
            beat_cnt_q <= '0;
            resp_q     <= 1'b0;
        end else begin
            resp_q <= 1'b0;
            case (state_q)
                fe_types_pkg::DESER_IDLE: begin
                    // req is still up in the resp cycle
                    if (mem_line.req && !resp_q) begin
                        state_q <= fe_types_pkg::DESER_ISSUE;
                    end
                end
                fe_types_pkg::DESER_ISSUE: begin
                    if (bmem_ready_i) begin
                        beat_cnt_q <= '0;
                        state_q    <= fe_types_pkg::DESER_COLLECT;
                    end
                end
                fe_types_pkg::DESER_COLLECT: begin
                    if (beat_hit) begin
                        beat_cnt_q <= beat_cnt_q + 1'b1;
                        if (beat_cnt_q == fe_params_pkg::BEAT_CNT_BITS'(
                                fe_params_pkg::BEATS_PER_LINE - 1)) begin
                            resp_q  <= 1'b1;
                            state_q <= fe_types_pkg::DESER_IDLE;
                        end
                    end
                end
                default: state_q <= fe_types_pkg::DESER_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == fe_types_pkg::DESER_IDLE && mem_line.req && !resp_q) begin
            addr_q <= {mem_line.addr[fe_params_pkg::XLEN-1:fe_params_pkg::OFFSET_BITS],
                       {fe_params_pkg::OFFSET_BITS{1'b0}}};
        end
        // beat k ends up at bits 64k and up
        if (state_q == fe_types_pkg::DESER_COLLECT && beat_hit) begin
            line_q <= {bmem_rdata_i,
                       line_q[fe_params_pkg::LINE_BITS-1:fe_params_pkg::BEAT_BITS]};
        end
    end

endmodule

`default_nettype wire

/* source/frontend_top.sv */
`timescale 1ns/1ns
`default_nettype none

module frontend_top (
    input  logic                                clk,
    input  logic                                rst,

    input  logic                                redirect_i,
    input  logic [fe_params_pkg::XLEN-1:0]      redirect_pc_i,

    output logic                                fq_valid_o,
    output fe_types_pkg::fetch_entry_t          fq_entry_o,
    input  logic                                fq_ready_i,

    input  logic                                dline_req_i,
    input  logic [fe_params_pkg::XLEN-1:0]      dline_addr_i,
    output logic [fe_params_pkg::LINE_BITS-1:0] dline_data_o,
    output logic                                dline_resp_o,

    output logic [fe_params_pkg::XLEN-1:0]      bmem_addr_o,
    output logic                                bmem_read_o,
    input  logic                                bmem_ready_i,
    input  logic [fe_params_pkg::XLEN-1:0]      bmem_raddr_i,
    input  logic [fe_params_pkg::BEAT_BITS-1:0] bmem_rdata_i,
    input  logic                                bmem_rvalid_i
);

    line_req_if inst_line ();
    line_req_if data_line ();
    line_req_if mem_line ();

    logic                       q_push;
    logic                       q_flush;
    logic                       q_full;
    logic                       q_pop;
    fe_types_pkg::fetch_entry_t q_entry;

    assign data_line.req  = dline_req_i;
    assign data_line.addr = dline_addr_i;
    assign dline_data_o   = data_line.line;
    assign dline_resp_o   = data_line.resp;

    fetch_unit ifetch (
        .clk           (clk),
        .rst           (rst),
        .redirect_i    (redirect_i),
        .redirect_pc_i (redirect_pc_i),
        .q_full_i      (q_full),
        .q_pop_i       (q_pop),
        .q_push_o      (q_push),
        .q_entry_o     (q_entry),
        .q_flush_o     (q_flush),
        .inst_line     (inst_line.requester)
    );

    inst_queue iqueue (
        .clk          (clk),
        .rst          (rst),
        .flush_i      (q_flush),
        .push_i       (q_push),
        .entry_i      (q_entry),
        .full_o       (q_full),
        .pop_o        (q_pop),
        .head_valid_o (fq_valid_o),
        .head_o       (fq_entry_o),
        .head_ready_i (fq_ready_i)
    );

    line_arbiter arbiter (
        .clk       (clk),
        .rst       (rst),
        .inst_line (inst_line.responder),
        .data_line (data_line.responder),
        .mem_line  (mem_line.requester)
    );

    burst_deserializer deser (
        .clk           (clk),
        .rst           (rst),
        .mem_line      (mem_line.responder),
        .bmem_addr_o   (bmem_addr_o),
        .bmem_read_o   (bmem_read_o),
        .bmem_ready_i  (bmem_ready_i),
        .bmem_raddr_i  (bmem_raddr_i),
        .bmem_rdata_i  (bmem_rdata_i),
        .bmem_rvalid_i (bmem_rvalid_i)
    );

endmodule

`default_nettype wire

/* verif/frontend_asserts.sv */
`timescale 1ns/1ns
`default_nettype none

module frontend_asserts (
    input logic                                clk,
    input logic                                rst,
    input logic                                redirect_i,
    input logic [fe_params_pkg::XLEN-1:0]      redirect_pc_i,
    input logic                                fq_valid_o,
    input fe_types_pkg::fetch_entry_t          fq_entry_o,
    input logic                                fq_ready_i,
    input logic [fe_params_pkg::XLEN-1:0]      dline_addr_i,
    input logic [fe_params_pkg::LINE_BITS-1:0] dline_data_o,
    input logic                                dline_resp_o,
    input logic [fe_params_pkg::XLEN-1:0]      bmem_addr_o,
    input logic                                bmem_read_o,
    input logic                                bmem_rvalid_i
);

    localparam logic [31:0] MEM_KEY = 32'h1357_9bdf;

    int fail_cnt = 0;

    logic                                 accept;
    logic [fe_params_pkg::ORDER_BITS-1:0] accept_cnt_q;
    logic [fe_params_pkg::XLEN-1:0]       exp_pc_q;
    logic [2:0]                           beats_left_q;
    logic [fe_params_pkg::XLEN-1:0]       word_addr;
    logic                                 dline_ok;
    logic [fe_params_pkg::XLEN-1:0]       dline_exp;
    logic [fe_params_pkg::XLEN-1:0]       dline_act;

    assign accept = fq_valid_o && fq_ready_i;

    // first wrong word of a returned data line
    always_comb begin
        dline_ok  = 1'b1;
        dline_exp = '0;
        dline_act = '0;
        word_addr = '0;
        for (int i = 0; i < fe_params_pkg::WORDS_PER_LINE; i++) begin
            word_addr = {dline_addr_i[31:5], 5'b00000} + 32'(4 * i);
            if (dline_ok && dline_data_o[32*i +: 32] != (word_addr ^ MEM_KEY)) begin
                dline_ok  = 1'b0;
                dline_exp = word_addr ^ MEM_KEY;
                dline_act = dline_data_o[32*i +: 32];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            accept_cnt_q <= '0;
            exp_pc_q     <= fe_params_pkg::RESET_PC;
            beats_left_q <= '0;
        end else begin
            if (accept) begin
                accept_cnt_q <= accept_cnt_q + 64'd1;
            end
            // a redirect overrides the sequential next pc
            if (redirect_i) begin
                exp_pc_q <= redirect_pc_i;
            end else if (accept) begin
                exp_pc_q <= exp_pc_q + 32'd4;
            end
            if (bmem_read_o) begin
                beats_left_q <= 3'd4;
            end else if (bmem_rvalid_i && beats_left_q != 3'd0) begin
                beats_left_q <= beats_left_q - 3'd1;
            end
        end
    end

    inst_rule: assert property (@(posedge clk) disable iff (rst)
        accept |-> fq_entry_o.inst == (fq_entry_o.pc ^ MEM_KEY))
    else begin
        fail_cnt++;
        $error("[FAIL] inst_rule expected %h actual %h",
               $sampled(fq_entry_o.pc) ^ MEM_KEY, $sampled(fq_entry_o.inst));
    end

    order_seq: assert property (@(posedge clk) disable iff (rst)
        accept |-> fq_entry_o.order == accept_cnt_q)
    else begin
        fail_cnt++;
        $error("[FAIL] order_seq expected %0d actual %0d",
               $sampled(accept_cnt_q), $sampled(fq_entry_o.order));
    end

    // covers both pc+4 steps and the first entry after a redirect
    pc_seq: assert property (@(posedge clk) disable iff (rst)
        accept |-> fq_entry_o.pc == exp_pc_q)
    else begin
        fail_cnt++;
        $error("[FAIL] pc_seq expected %h actual %h",
               $sampled(exp_pc_q), $sampled(fq_entry_o.pc));
    end

    head_hold: assert property (@(posedge clk) disable iff (rst)
        fq_valid_o && !fq_ready_i && !redirect_i |=> $stable(fq_entry_o))
    else begin
        fail_cnt++;
        $error("[FAIL] head_hold expected %h actual %h",
               $past(fq_entry_o), $sampled(fq_entry_o));
    end

    dline_rule: assert property (@(posedge clk) disable iff (rst)
        dline_resp_o |-> dline_ok)
    else begin
        fail_cnt++;
        $error("[FAIL] dline_rule expected %h actual %h",
               $sampled(dline_exp), $sampled(dline_act));
    end

    // one pulse per burst, line aligned, previous burst complete
    bmem_read_rule: assert property (@(posedge clk) disable iff (rst)
        bmem_read_o |-> beats_left_q == 3'd0 && bmem_addr_o[4:0] == 5'd0)
    else begin
        fail_cnt++;
        $error("bmem_read_o raised at %h with %0d beats of the previous read missing",
               $sampled(bmem_addr_o), $sampled(beats_left_q));
    end

endmodule

bind frontend_top frontend_asserts chk (
    .clk           (clk),
    .rst           (rst),
    .redirect_i    (redirect_i),
    .redirect_pc_i (redirect_pc_i),
    .fq_valid_o    (fq_valid_o),
    .fq_entry_o    (fq_entry_o),
    .fq_ready_i    (fq_ready_i),
    .dline_addr_i  (dline_addr_i),
    .dline_data_o  (dline_data_o),
    .dline_resp_o  (dline_resp_o),
    .bmem_addr_o   (bmem_addr_o),
    .bmem_read_o   (bmem_read_o),
    .bmem_rvalid_i (bmem_rvalid_i)
);

`default_nettype wire

/* verif/tb_frontend.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_frontend;

    localparam int CLK_PERIOD = 40;
    localparam int RESET_CYCLES = 5;
    localparam logic [31:0] MEM_KEY = 32'h1357_9bdf;
    // issue wait, 8 cycle memory delay, four beats, resp and refetch
    localparam int FILL_WORST = 40;
    localparam int TEST_CYCLES = 600;
    localparam int MARGIN_CYCLES = 1000;
    localparam int WAIT_LIMIT = 400;

    logic                                clk = 1'b0;
    logic                                rst;
    logic                                redirect_i;
    logic [fe_params_pkg::XLEN-1:0]      redirect_pc_i;
    logic                                fq_valid_o;
    fe_types_pkg::fetch_entry_t          fq_entry_o;
    logic                                fq_ready_i;
    logic                                dline_req_i;
    logic [fe_params_pkg::XLEN-1:0]      dline_addr_i;
    logic [fe_params_pkg::LINE_BITS-1:0] dline_data_o;
    logic                                dline_resp_o;
    logic [fe_params_pkg::XLEN-1:0]      bmem_addr_o;
    logic                                bmem_read_o;
    logic                                bmem_ready_i;
    logic [fe_params_pkg::XLEN-1:0]      bmem_raddr_i;
    logic [fe_params_pkg::BEAT_BITS-1:0] bmem_rdata_i;
    logic                                bmem_rvalid_i;

    integer seed = 32'hfa47_940d;
    int     timeout_cnt = 0;
    logic   hold_ready;

    frontend_top UUT (
        .clk           (clk),
        .rst           (rst),
        .redirect_i    (redirect_i),
        .redirect_pc_i (redirect_pc_i),
        .fq_valid_o    (fq_valid_o),
        .fq_entry_o    (fq_entry_o),
        .fq_ready_i    (fq_ready_i),
        .dline_req_i   (dline_req_i),
        .dline_addr_i  (dline_addr_i),
        .dline_data_o  (dline_data_o),
        .dline_resp_o  (dline_resp_o),
        .bmem_addr_o   (bmem_addr_o),
        .bmem_read_o   (bmem_read_o),
        .bmem_ready_i  (bmem_ready_i),
        .bmem_raddr_i  (bmem_raddr_i),
        .bmem_rdata_i  (bmem_rdata_i),
        .bmem_rvalid_i (bmem_rvalid_i)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic logic [31:0] mem_word(input logic [31:0] addr);
        return addr ^ MEM_KEY;
    endfunction

    // burst memory, read seen at negedge, beats after 2 to 8 cycles
    initial begin : memory_model
        logic [31:0] line_addr;
        int          delay;
        bmem_rvalid_i = 1'b0;
        bmem_raddr_i  = '0;
        bmem_rdata_i  = '0;
        forever begin
            @(negedge clk);
            if (!rst && bmem_read_o) begin
                line_addr = bmem_addr_o;
                delay = 2 + ($unsigned($random(seed)) % 7);
                repeat (delay) @(posedge clk);
                for (int k = 0; k < 4; k++) begin
                    #2;
                    bmem_rvalid_i = 1'b1;
                    bmem_raddr_i  = line_addr;
                    bmem_rdata_i  = {mem_word(line_addr + 32'(8 * k + 4)),
                                     mem_word(line_addr + 32'(8 * k))};
                    @(posedge clk);
                end
                #2;
                bmem_rvalid_i = 1'b0;
            end
        end
    end

    initial begin : ready_noise
        logic [31:0] rnd;
        bmem_ready_i = 1'b0;
        fq_ready_i   = 1'b0;
        forever begin
            @(posedge clk);
            rnd = $random(seed);
            #2;
            bmem_ready_i = rnd[1:0] != 2'b00;
            fq_ready_i   = !hold_ready && rnd[4];
        end
    end

    task automatic idle(input int n);
        repeat (n) @(posedge clk);
        #2;
    endtask

    task automatic wait_accepts(input int n);
        int seen;
        int cycles;
        seen = 0;
        cycles = 0;
        while (seen < n && cycles < WAIT_LIMIT) begin
            @(negedge clk);
            if (fq_valid_o && fq_ready_i) begin
                seen++;
            end
            cycles++;
        end
        if (seen < n) begin
            timeout_cnt++;
            $display("timeout: only %0d of %0d queue handshakes in %0d cycles",
                     seen, n, WAIT_LIMIT);
        end
        idle(1);
    endtask

    task automatic read_data_line(input logic [31:0] addr);
        int cycles;
        cycles = 0;
        dline_req_i  = 1'b1;
        dline_addr_i = addr;
        @(negedge clk);
        while (!dline_resp_o && cycles < WAIT_LIMIT) begin
            @(negedge clk);
            cycles++;
        end
        if (!dline_resp_o) begin
            timeout_cnt++;
            $display("timeout: no dline_resp_o for line %h in %0d cycles", addr, WAIT_LIMIT);
        end
        idle(1);
        dline_req_i = 1'b0;
        idle(1);
    endtask

    task automatic redirect_to(input logic [31:0] target);
        redirect_i    = 1'b1;
        redirect_pc_i = target;
        idle(1);
        redirect_i = 1'b0;
    endtask

    task automatic stall_queue(input int cycles);
        @(posedge clk);
        hold_ready = 1'b1;
        repeat (cycles) @(posedge clk);
        hold_ready = 1'b0;
        #2;
    endtask

    initial begin : stimulus
        logic [31:0] target;
        rst           = 1'b1;
        redirect_i    = 1'b0;
        redirect_pc_i = '0;
        dline_req_i   = 1'b0;
        dline_addr_i  = '0;
        hold_ready    = 1'b0;
        idle(RESET_CYCLES);
        rst = 1'b0;

        wait_accepts(40);
        redirect_to(32'h6000_0014);
        wait_accepts(20);
        read_data_line(32'h6000_0400);
        redirect_to(32'h6000_2000);
        idle(1);
        // fill for 0x6000_2000 should still be pending
        redirect_to(32'h6000_0f38);
        wait_accepts(30);
        stall_queue(40);
        wait_accepts(20);
        for (int i = 0; i < 8; i++) begin
            target = 32'h6000_0000 | ($random(seed) & 32'h0000_ffe0);
            read_data_line(target);
            target = 32'h6000_0000 | ($random(seed) & 32'h0000_fffc);
            redirect_to(target);
            wait_accepts(10 + i);
        end
        read_data_line(32'h7000_0044);
        wait_accepts(20);

        $display("checks done: %0d assertion failures, %0d timeouts",
                 UUT.chk.fail_cnt, timeout_cnt);
        if (UUT.chk.fail_cnt == 0 && timeout_cnt == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

    initial begin : watchdog
        repeat (TEST_CYCLES * FILL_WORST + MARGIN_CYCLES) @(posedge clk);
        $display("watchdog expired, run stopped before the stimulus ended");
        $display("Verification failed");
        $finish;
    end

endmodule

`default_nettype wire

/* project.f */
source/fe_params_pkg.sv
source/fe_types_pkg.sv
source/line_req_if.sv
source/fetch_unit.sv
source/inst_queue.sv
source/line_arbiter.sv
source/burst_deserializer.sv
source/frontend_top.sv
verif/frontend_asserts.sv
verif/tb_frontend.sv

/* Makefile */
# Verilator build and run of the fetch front end testbench

VERILATOR ?= verilator
TOP       ?= tb_frontend
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
JOBS      ?= 0
VFLAGS    ?= --binary --timing --assert -Wno-fatal
SIMFLAGS  ?= +verilator+error+limit+1000

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run $(TOP), check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"

test:
	$(VERILATOR) $(VFLAGS) -j $(JOBS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	-./$(BUILD_DIR)/V$(TOP) $(SIMFLAGS) 2>&1 | tee $(LOG)
	@if grep -q "Verification failed" $(LOG); then \
		echo "test failed, see $(LOG)"; exit 1; \
	elif ! grep -q "Verification passed" $(LOG); then \
		echo "no result line in $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
